// File: sim.f
source/rs_pkg.sv
source/rs_entry.sv
source/rs_select.sv
source/fu_sequencer.sv
source/latency_timer.sv
source/alu_exec.sv
source/rs_cluster.sv
verification/rs_cluster_assert.sv
verification/rs_cluster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
    --top-module rs_cluster_tb -f sim.f -o rs_cluster_sim \
    && ./obj_dir/rs_cluster_sim | tee /dev/stderr | grep -q "Simulation passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: verification/rs_cluster_tb.sv
/*
 * Testbench for the issue cluster with random and dependent dispatch,
 * a reference model of results and CDB checks
 */
module rs_cluster_tb import rs_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR = 20;  // Dispatches over the whole run
    localparam int CYCLE     = 100;

    logic clock = 1'b0;
    logic reset;
    logic dispatch_valid, dispatch_branch, opa_ready, opb_ready;
    alu_func_t dispatch_func;
    logic [TAG_WIDTH-1:0]  dispatch_tag;
    logic [DATA_WIDTH-1:0] dispatch_npc, opa_value, opb_value;
    logic rs_full, cdb_valid, cdb_branch;
    logic [TAG_WIDTH-1:0]  cdb_tag;
    logic [DATA_WIDTH-1:0] cdb_value, cdb_npc;

    logic [DATA_WIDTH-1:0] exp_value  [32];  // Model results by tag
    logic [DATA_WIDTH-1:0] exp_npc    [32];
    logic                  exp_branch [32];
    logic                  pending    [32];
    logic                  done       [32];
    int next_tag  = 0;
    int accepted  = 0;
    int completed = 0;
    int errors    = 0;

    rs_cluster #(.NUM_ENTRIES(4)) i_rs_cluster (.*);

    always #(CYCLE / 2) clock = ~clock;

    function automatic logic [DATA_WIDTH-1:0] alu_model(alu_func_t f, logic [31:0] a,
                                                       logic [31:0] b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a * b;  // Low 32 bits of product
        endcase
    endfunction

    // Source below zero means a fresh random value
    task automatic resolve(input int src, output logic [31:0] value, output logic rdy,
                           output logic [31:0] model);
        if (src < 0) begin
            value = $urandom;
            rdy   = 1'b1;
            model = value;
        end else if (done[src]) begin
            value = exp_value[src];  // Producer already broadcast
            rdy   = 1'b1;
            model = value;
        end else begin
            value = 32'(src);  // Producer tag in low bits
            rdy   = 1'b0;
            model = exp_value[src];
        end
    endtask

    // Starts and ends 10 ns after a rising edge
    task automatic send(input alu_func_t f, input int src_a, input int src_b);
        logic [31:0] a_model;
        logic [31:0] b_model;
        while (rs_full) begin
            @(posedge clock);
            #10;
        end
        resolve(src_a, opa_value, opa_ready, a_model);
        resolve(src_b, opb_value, opb_ready, b_model);
        dispatch_func   = f;
        dispatch_tag    = TAG_WIDTH'(next_tag);
        dispatch_npc    = $urandom;
        dispatch_branch = 1'($urandom);
        dispatch_valid  = 1'b1;
        @(posedge clock);
        exp_value[next_tag]  = alu_model(f, a_model, b_model);
        exp_npc[next_tag]    = dispatch_npc;
        exp_branch[next_tag] = dispatch_branch;
        pending[next_tag]    = 1'b1;
        next_tag++;
        accepted++;
        #10;
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_broadcast(input int tag);
        while (!(cdb_valid && cdb_tag == TAG_WIDTH'(tag))) begin
            @(posedge clock);
            #10;
        end
    endtask

    task automatic wait_drain();
        while (completed < accepted) begin
            @(posedge clock);
            #10;
        end
    endtask

    ////////////////////
    // CDB checker
    ////////////////////
    always @(posedge clock) begin
        if (!reset && cdb_valid) begin
            assert (pending[cdb_tag]) else begin
                errors++;
                $display("[FAIL] %0t: unexpected broadcast of tag %0d", $time, cdb_tag);
            end
            assert (cdb_value == exp_value[cdb_tag] && cdb_npc == exp_npc[cdb_tag]
                    && cdb_branch == exp_branch[cdb_tag]) else begin
                errors++;
                $display("[FAIL] %0t: tag %0d value %h expected %h", $time, cdb_tag,
                         cdb_value, exp_value[cdb_tag]);
            end
            if (pending[cdb_tag])
                completed++;
            pending[cdb_tag] = 1'b0;
            done[cdb_tag]    = 1'b1;
        end
    end

    initial begin
        #(CYCLE * (NUM_INSTR * (MUL_LATENCY + 3) + 200));
        $display("Timeout: the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        int p;
        alu_func_t chain_f [3] = '{ALU_ADD, ALU_SUB, ALU_XOR};
        void'($urandom(78526));
        foreach (pending[i]) begin
            pending[i] = 1'b0;
            done[i]    = 1'b0;
        end
        {dispatch_valid, dispatch_branch, opa_ready, opb_ready} = '0;
        dispatch_func = ALU_ADD;
        {dispatch_tag, dispatch_npc, opa_value, opb_value} = '0;
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #10;
        reset = 1'b0;
        for (int i = 0; i < 10; i++)  // Random mix with some dependents
            send(alu_func_t'($urandom_range(6)),
                 (i > 0 && $urandom_range(2) == 0) ? next_tag - 1 : -1, -1);
        p = next_tag;
        send(ALU_MUL, -1, -1);
        for (int i = 0; i < 3; i++) begin  // Dispatch in producer's CDB cycle
            wait_broadcast(p);
            p = next_tag;
            send(chain_f[i], p - 1, p - 1);
        end
        wait_drain();
        p = next_tag;
        send(ALU_MUL, -1, -1);
        for (int i = 0; i < 4; i++)  // Operand A, B or both wait on the multiply
            send(ALU_ADD, (i == 1) ? -1 : p, (i == 0) ? -1 : p);
        assert (rs_full) else begin
            errors++;
            $display("[FAIL] %0t: station not full after four waiting entries", $time);
        end
        dispatch_tag   = 5'd31;  // Must be dropped
        dispatch_valid = 1'b1;
        @(posedge clock);
        #10;
        dispatch_valid = 1'b0;
        wait_drain();
        repeat (10) @(posedge clock);
        $display("Errors: %0d check, %0d assertion, %0d missing broadcasts", errors,
                 i_rs_cluster.i_rs_cluster_assert.fail_count, accepted - completed);
        if (errors == 0 && i_rs_cluster.i_rs_cluster_assert.fail_count == 0
                && completed == accepted)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: verification/rs_cluster_assert.sv
/*
 * Concurrent protocol checks for the issue cluster CDB and full flag
 */
module rs_cluster_assert import rs_pkg::*; (
    input logic      clock,
    input logic      reset,
    input logic      cdb_valid,
    input logic      issue_strobe,
    input alu_func_t issue_func,   // Function of the picked entry
    input logic      fu_busy,
    input logic      rs_full
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Assertion failures so far

    // Quiet state right after reset
    reset_state: assert property (@(posedge clock) reset |=> !cdb_valid && !fu_busy && !rs_full)
        else begin
            fail_count++;
            $error("CDB, FU or full flag active after reset");
        end

    // One-cycle broadcast and minimum spacing
    cdb_gap: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |=> !cdb_valid [*ALU_LATENCY + 1])
        else begin
            fail_count++;
            $error("CDB broadcasts too close together");
        end

    // Multiply result shows up LAT+1 cycles after the issue edge
    mul_gap: assert property (@(posedge clock) disable iff (reset)
        issue_strobe && issue_func == ALU_MUL |=> !cdb_valid [*MUL_LATENCY + 1] ##1 cdb_valid)
        else begin
            fail_count++;
            $error("Multiply result broadcast at the wrong time");
        end

    full_drop: assert property (@(posedge clock) disable iff (reset)
        issue_strobe && rs_full |=> !rs_full)
        else begin
            fail_count++;
            $error("Station stayed full after an issue");
        end

endmodule

bind rs_cluster rs_cluster_assert i_rs_cluster_assert (
    .clock        (clock),
    .reset        (reset),
    .cdb_valid    (cdb_valid),
    .issue_strobe (issue_strobe),
    .issue_func   (entry_func[issue_pick]),
    .fu_busy      (fu_busy),
    .rs_full      (rs_full)
);

// File: source/rs_cluster.sv
/*
 * Issue cluster top: reservation-station entries, selector, sequencer,
 * latency timer and the functional unit driving the CDB
 */
module rs_cluster import rs_pkg::*; #(
    parameter int  NUM_ENTRIES = 4,
    localparam int IDX_WIDTH   = $clog2(NUM_ENTRIES)
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  alu_func_t             dispatch_func,
    input  logic [TAG_WIDTH-1:0]  dispatch_tag,
    input  logic [DATA_WIDTH-1:0] dispatch_npc,
    input  logic                  dispatch_branch,
    input  logic [DATA_WIDTH-1:0] opa_value,
    input  logic [DATA_WIDTH-1:0] opb_value,
    input  logic                  opa_ready,
    input  logic                  opb_ready,
    output logic                  rs_full,
    output logic                  cdb_valid,
    output logic [TAG_WIDTH-1:0]  cdb_tag,
    output logic [DATA_WIDTH-1:0] cdb_value,
    output logic [DATA_WIDTH-1:0] cdb_npc,
    output logic                  cdb_branch
);

    logic [NUM_ENTRIES-1:0] busy_vec;
    logic [NUM_ENTRIES-1:0] ready_vec;
    logic [NUM_ENTRIES-1:0] alloc_grant;
    logic [IDX_WIDTH-1:0]   issue_pick;
    logic                   any_ready;
    logic                   issue_strobe;
    logic                   fu_busy;
    logic                   exec_done;

    alu_func_t             entry_func   [NUM_ENTRIES];
    logic [TAG_WIDTH-1:0]  entry_tag    [NUM_ENTRIES];
    logic [DATA_WIDTH-1:0] entry_npc    [NUM_ENTRIES];
    logic                  entry_branch [NUM_ENTRIES];
    logic [DATA_WIDTH-1:0] entry_opa    [NUM_ENTRIES];
    logic [DATA_WIDTH-1:0] entry_opb    [NUM_ENTRIES];

    ////////////////////
    // Entries
    ////////////////////
    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
        rs_entry i_rs_entry (
            .clock     (clock),
            .reset     (reset),
            .load      (dispatch_valid && !rs_full && alloc_grant[i]),
            .free      (issue_strobe && (issue_pick == IDX_WIDTH'(i))),
            .in_func   (dispatch_func),
            .in_tag    (dispatch_tag),
            .in_npc    (dispatch_npc),
            .in_branch (dispatch_branch),
            .opa_in    (opa_value),
            .opb_in    (opb_value),
            .opa_ready (opa_ready),
            .opb_ready (opb_ready),
            .cdb_valid (cdb_valid),   // Wakeup feedback
            .cdb_tag   (cdb_tag),
            .cdb_value (cdb_value),
            .busy      (busy_vec[i]),
            .ready     (ready_vec[i]),
            .func      (entry_func[i]),
            .tag       (entry_tag[i]),
            .npc       (entry_npc[i]),
            .branch    (entry_branch[i]),
            .opa       (entry_opa[i]),
            .opb       (entry_opb[i])
        );
    end

    rs_select #(.NUM_ENTRIES(NUM_ENTRIES)) i_rs_select (
        .busy_vec    (busy_vec),
        .ready_vec   (ready_vec),
        .alloc_grant (alloc_grant),
        .rs_full     (rs_full),
        .any_ready   (any_ready),
        .issue_pick  (issue_pick)
    );

    fu_sequencer i_fu_sequencer (
        .clock        (clock),
        .reset        (reset),
        .any_ready    (any_ready),
        .exec_done    (exec_done),
        .issue_strobe (issue_strobe),
        .fu_busy      (fu_busy),    // Ready entries hold while set
        .cdb_valid    (cdb_valid)
    );

    ////////////////////
    // Execution
    ////////////////////
    latency_timer i_latency_timer (
        .clock     (clock),
        .reset     (reset),
        .start     (issue_strobe),
        .func      (entry_func[issue_pick]),  // Picked entry's function
        .exec_done (exec_done)
    );

    alu_exec i_alu_exec (
        .clock      (clock),
        .reset      (reset),
        .capture    (issue_strobe),
        .func       (entry_func[issue_pick]),
        .tag        (entry_tag[issue_pick]),
        .npc        (entry_npc[issue_pick]),
        .branch     (entry_branch[issue_pick]),
        .opa        (entry_opa[issue_pick]),
        .opb        (entry_opb[issue_pick]),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .cdb_npc    (cdb_npc),
        .cdb_branch (cdb_branch)
    );

endmodule

// File: source/alu_exec.sv
/*
 * Shared functional unit: latches the issued instruction and computes
 * its result from the held operands
 */
module alu_exec import rs_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  capture,     // Issue strobe
    input  alu_func_t             func,
    input  logic [TAG_WIDTH-1:0]  tag,
    input  logic [DATA_WIDTH-1:0] npc,
    input  logic                  branch,
    input  logic [DATA_WIDTH-1:0] opa,
    input  logic [DATA_WIDTH-1:0] opb,
    output logic [TAG_WIDTH-1:0]  cdb_tag,
    output logic [DATA_WIDTH-1:0] cdb_value,
    output logic [DATA_WIDTH-1:0] cdb_npc,
    output logic                  cdb_branch
);

    alu_func_t             func_q;
    logic [DATA_WIDTH-1:0] opa_q;
    logic [DATA_WIDTH-1:0] opb_q;

    // Held until the next issue
    always_ff @(posedge clock) begin
        if (reset) begin
            func_q     <= ALU_ADD;
            opa_q      <= '0;
            opb_q      <= '0;
            cdb_tag    <= '0;
            cdb_npc    <= '0;
            cdb_branch <= 1'b0;
        end else if (capture) begin
            func_q     <= func;
            opa_q      <= opa;
            opb_q      <= opb;
            cdb_tag    <= tag;
            cdb_npc    <= npc;
            cdb_branch <= branch;
        end
    end

    ////////////////////
    // Result
    ////////////////////
    always_comb begin
        case (func_q)
            ALU_ADD: cdb_value = opa_q + opb_q;
            ALU_SUB: cdb_value = opa_q - opb_q;
            ALU_AND: cdb_value = opa_q & opb_q;
            ALU_OR:  cdb_value = opa_q | opb_q;
            ALU_XOR: cdb_value = opa_q ^ opb_q;
            ALU_SLT: cdb_value = DATA_WIDTH'($signed(opa_q) < $signed(opb_q));
            ALU_MUL: cdb_value = opa_q * opb_q;  // Truncated to low half
            default: cdb_value = '0;
        endcase
    end

endmodule

// File: source/latency_timer.sv
/*
 * Execution latency counter, pulses exec_done on the last step
 */
module latency_timer import rs_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,      // Issue strobe
    input  alu_func_t func,       // Function being issued
    output logic      exec_done
);

    localparam int CNT_WIDTH = $clog2(MUL_LATENCY + 2);

    logic [CNT_WIDTH-1:0] count;  // Remaining steps, 0 when idle

    // Extra step covers the operand capture cycle
    always_ff @(posedge clock) begin
        if (reset)
            count <= '0;
        else if (start)
            count <= (func == ALU_MUL) ? CNT_WIDTH'(MUL_LATENCY + 1)
                                       : CNT_WIDTH'(ALU_LATENCY + 1);
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign exec_done = (count == CNT_WIDTH'(1));

endmodule

// File: source/fu_sequencer.sv
/*
 * Functional-unit sequencer: issues one ready instruction, waits
 * for execution and holds the CDB broadcast for one cycle
 */
module fu_sequencer (
    input  logic clock,
    input  logic reset,
    input  logic any_ready,     // Some entry can issue
    input  logic exec_done,     // Timer says result is valid
    output logic issue_strobe,  // Free entry, capture operands
    output logic fu_busy,
    output logic cdb_valid
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        EXEC  = 2'd1,
        BCAST = 2'd2
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clock) begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    ////////////////////
    // Next state
    ////////////////////
    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (any_ready) next_state = EXEC;
            EXEC:    if (exec_done) next_state = BCAST;
            BCAST:   next_state = IDLE;  // Single broadcast cycle
            default: next_state = IDLE;
        endcase
    end

    // Outputs decoded from state
    assign issue_strobe = (state == IDLE) && any_ready;
    assign fu_busy      = (state != IDLE);
    assign cdb_valid    = (state == BCAST);

endmodule

// File: source/rs_select.sv
/*
 * Entry selector: lowest free entry for dispatch, lowest ready entry
 * for issue, and the station-full flag
 */
module rs_select #(
    parameter int  NUM_ENTRIES = 4,
    localparam int IDX_WIDTH   = $clog2(NUM_ENTRIES)
) (
    input  logic [NUM_ENTRIES-1:0] busy_vec,
    input  logic [NUM_ENTRIES-1:0] ready_vec,
    output logic [NUM_ENTRIES-1:0] alloc_grant,  // One-hot, zero when full
    output logic                   rs_full,
    output logic                   any_ready,
    output logic [IDX_WIDTH-1:0]   issue_pick    // Valid with any_ready
);

    assign rs_full   = &busy_vec;
    assign any_ready = |ready_vec;

    ////////////////////
    // Dispatch finder
    ////////////////////
    always_comb begin
        alloc_grant = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!busy_vec[i])
                alloc_grant = NUM_ENTRIES'(1) << i;  // Lower index overrides
        end
    end

    ////////////////////
    // Issue finder
    ////////////////////
    always_comb begin
        issue_pick = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (ready_vec[i])
                issue_pick = IDX_WIDTH'(i);  // Lowest ready wins
        end
    end

endmodule

// File: source/rs_entry.sv
/*
 * Reservation-station entry: holds one renamed instruction, snoops the
 * CDB for missing operands and releases itself when issued
 */
module rs_entry import rs_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  load,       // Write dispatched instr
    input  logic                  free,       // Entry issued this cycle
    input  alu_func_t             in_func,
    input  logic [TAG_WIDTH-1:0]  in_tag,     // Destination ROB tag
    input  logic [DATA_WIDTH-1:0] in_npc,
    input  logic                  in_branch,
    input  logic [DATA_WIDTH-1:0] opa_in,     // Value or producer tag
    input  logic [DATA_WIDTH-1:0] opb_in,
    input  logic                  opa_ready,  // opa_in holds a value
    input  logic                  opb_ready,
    input  logic                  cdb_valid,
    input  logic [TAG_WIDTH-1:0]  cdb_tag,
    input  logic [DATA_WIDTH-1:0] cdb_value,
    output logic                  busy,
    output logic                  ready,
    output alu_func_t             func,
    output logic [TAG_WIDTH-1:0]  tag,
    output logic [DATA_WIDTH-1:0] npc,
    output logic                  branch,
    output logic [DATA_WIDTH-1:0] opa,
    output logic [DATA_WIDTH-1:0] opb
);

    logic [TAG_WIDTH-1:0] opa_tag;       // Producer of waiting operand A
    logic [TAG_WIDTH-1:0] opb_tag;       // Producer of waiting operand B
    logic                 opa_valid;
    logic                 opb_valid;
    logic                 opa_hit_load;  // Broadcast in dispatch cycle
    logic                 opb_hit_load;
    logic                 opa_wake;      // Broadcast while waiting
    logic                 opb_wake;

    ////////////////////
    // CDB tag match
    ////////////////////
    assign opa_hit_load = !opa_ready && cdb_valid && (opa_in[TAG_WIDTH-1:0] == cdb_tag);
    assign opb_hit_load = !opb_ready && cdb_valid && (opb_in[TAG_WIDTH-1:0] == cdb_tag);
    assign opa_wake     = busy && !opa_valid && cdb_valid && (opa_tag == cdb_tag);
    assign opb_wake     = busy && !opb_valid && cdb_valid && (opb_tag == cdb_tag);

    assign ready = busy && opa_valid && opb_valid;  // FU gating lives in sequencer

    // Occupancy and operand valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            opa_valid <= 1'b0;
            opb_valid <= 1'b0;
        end else if (load) begin
            busy      <= 1'b1;
            opa_valid <= opa_ready || opa_hit_load;  // Catch same-cycle result
            opb_valid <= opb_ready || opb_hit_load;
        end else if (free) begin
            busy      <= 1'b0;
            opa_valid <= 1'b0;
            opb_valid <= 1'b0;
        end else begin
            if (opa_wake)
                opa_valid <= 1'b1;
            if (opb_wake)
                opb_valid <= 1'b1;
        end
    end

    // Instruction payload and operand values
    always_ff @(posedge clock) begin
        if (load) begin
            func    <= in_func;
            tag     <= in_tag;
            npc     <= in_npc;
            branch  <= in_branch;
            opa_tag <= opa_in[TAG_WIDTH-1:0];  // Only meaningful when waiting
            opb_tag <= opb_in[TAG_WIDTH-1:0];
            opa     <= opa_hit_load ? cdb_value : opa_in;
            opb     <= opb_hit_load ? cdb_value : opb_in;
        end else begin
            if (opa_wake)
                opa <= cdb_value;
            if (opb_wake)
                opb <= cdb_value;  // Same tag may wake both
        end
    end

endmodule

// File: source/rs_pkg.sv
/*
 * Shared widths, ALU function encoding and execution latencies
 * for the reservation-station issue cluster
 */
package rs_pkg;

    ////////////////////
    // Datapath widths
    ////////////////////
    parameter int DATA_WIDTH = 32;  // Operand and result width
    parameter int TAG_WIDTH  = 5;   // ROB tag width, tag 0 is legal

    ////////////////////
    // ALU functions
    ////////////////////
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,  // Signed less-than, 1 or 0
        ALU_MUL = 3'd6   // Low half of product
    } alu_func_t;

    ////////////////////
    // Latencies
    ////////////////////
    // Cycles spent in the functional unit per function class
    parameter int ALU_LATENCY = 1;  // Every function but multiply
    parameter int MUL_LATENCY = 3;  // Multiply only

endpackage
